// File: hdl/decode_pkg.sv
// shared types and constants for the four-stage x86 instruction decoder
// each stage hands one of the structs below to the next, and the top level
// drives a decoded_t to the consumer of the decoded fields
// import with decode_pkg::* inside a module body
package decode_pkg;

    localparam int window_bytes = 12; // prefix, opcode, modrm, sib, disp32, imm32
    localparam logic [7:0] operand_size_prefix = 8'h66;

    // byte 0 is the first byte in memory
    typedef logic [window_bytes-1:0][7:0] byte_window_t;

    // one-hot field length in the order 8, 16, 32, full, all zero when absent
    typedef logic [3:0] length_code_t;
    localparam length_code_t len_none = 4'b0000;
    localparam length_code_t len_8    = 4'b0001;
    localparam length_code_t len_16   = 4'b0010;
    localparam length_code_t len_32   = 4'b0100;
    localparam length_code_t len_full = 4'b1000; // far pointer code, never produced here

    typedef enum logic [2:0] {
        op_alu_rm_reg,  // 00-3f with low bits 0-3
        op_alu_acc_imm, // 00-3f with low bits 4-5
        op_alu_rm_imm,  // 80, 81, 83
        op_mov_reg_imm, // b0-bf
        op_invalid
    } opcode_class_t;

    typedef struct packed {
        logic         valid;
        logic         operand_size_16;
        byte_window_t window;          // opcode sits in byte 0
        logic         prefix_count;
    } prefix_stage_t;

    typedef struct packed {
        logic          valid;
        logic          operand_size_16;
        logic          prefix_count;
        logic [7:0]    opcode;
        opcode_class_t opcode_class;
        logic          has_modrm;
        length_code_t  immediate_length;
        byte_window_t  window;         // starts right after the opcode
    } opcode_stage_t;

    // reg is a keyword, so the ModR/M reg field is called reg_field throughout
    typedef struct packed {
        logic          valid;
        logic          operand_size_16;
        logic          prefix_count;
        logic [7:0]    opcode;
        opcode_class_t opcode_class;
        logic          has_modrm;
        length_code_t  immediate_length;
        logic [2:0]    reg_field;
        logic [2:0]    rm;
        logic          has_sib;
        logic [1:0]    sib_scale;
        logic [2:0]    sib_index;
        logic [2:0]    sib_base;
        length_code_t  displacement_length;
        byte_window_t  window;         // starts at the displacement
    } modrm_stage_t;

    typedef struct packed {
        logic          valid;
        opcode_class_t opcode_class;
        logic [7:0]    opcode;
        logic          operand_size_16;
        logic [2:0]    reg_field;
        logic [2:0]    rm;
        logic          has_sib;
        logic [1:0]    sib_scale;
        logic [2:0]    sib_index;
        logic [2:0]    sib_base;
        logic [31:0]   displacement;        // zero-extended
        length_code_t  displacement_length;
        logic [31:0]   immediate;           // zero-extended
        length_code_t  immediate_length;
        logic [3:0]    instruction_length;  // in bytes
    } decoded_t;

    // number of window bytes a length code takes up
    function automatic logic [2:0] length_bytes(length_code_t code);
        case (code)
            len_8:            return 3'd1;
            len_16:           return 3'd2;
            len_32, len_full: return 3'd4; // full shares the 32-bit slot in the window
            default:          return 3'd0;
        endcase
    endfunction

endpackage

// File: hdl/decode_stage_1.sv
// decode stage 1, operand-size prefix
// looks for a 0x66 prefix at the front of the window and removes it, so the
// stages after this one always find the opcode in byte 0
// one cycle of latency, a new window may arrive every cycle
module decode_stage_1 (
    input  logic                      clk,
    input  logic                      rst,
    input  decode_pkg::byte_window_t  window,
    input  logic                      window_valid,
    output decode_pkg::prefix_stage_t prefix_out
);
    import decode_pkg::*;

    prefix_stage_t prefix_next;
    logic          has_prefix;
    byte_window_t  shifted_window;

    assign has_prefix = (window[0] == operand_size_prefix);

    // drop byte 0 and fill the top of the window with zero
    assign shifted_window = {8'h00, window[window_bytes-1:1]};

    always_comb begin
        prefix_next.valid           = window_valid;
        prefix_next.operand_size_16 = has_prefix;
        prefix_next.prefix_count    = has_prefix; // at most one prefix is recognised
        prefix_next.window          = has_prefix ? shifted_window : window;
    end

    always_ff @(posedge clk) begin
        prefix_out <= prefix_next;
        if (rst) begin
            prefix_out.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/decode_stage_2.sv
// decode stage 2, opcode
// sorts the one-byte opcode into an opcode class, works out whether a
// ModR/M byte follows and how long the immediate is, and moves the
// window past the opcode so the next stage sees ModR/M in byte 0
module decode_stage_2 (
    input  logic                      clk,
    input  logic                      rst,
    input  decode_pkg::prefix_stage_t prefix_in,
    output decode_pkg::opcode_stage_t opcode_out
);
    import decode_pkg::*;

    opcode_stage_t opcode_next;
    logic [7:0]    opcode;
    opcode_class_t opcode_class;
    length_code_t  full_size;     // immediate size for the word/dword forms
    length_code_t  immediate_length;

    assign opcode = prefix_in.window[0];

    always_comb begin
        unique casez (opcode)
            8'b00??_?0??:                opcode_class = op_alu_rm_reg;  // add..cmp r/m, reg
            8'b00??_?10?:                opcode_class = op_alu_acc_imm; // al or eax with imm
            8'h80, 8'h81, 8'h83:         opcode_class = op_alu_rm_imm;
            8'b1011_????:                opcode_class = op_mov_reg_imm;
            default:                     opcode_class = op_invalid;
        endcase
    end

    assign full_size = prefix_in.operand_size_16 ? len_16 : len_32;

    always_comb begin
        unique case (opcode_class)
            op_alu_acc_imm, op_alu_rm_imm: begin
                // low bit clear is the byte form, 83 sign-extends a byte
                if (!opcode[0] || opcode == 8'h83) begin
                    immediate_length = len_8;
                end else begin
                    immediate_length = full_size;
                end
            end
            op_mov_reg_imm: immediate_length = opcode[3] ? full_size : len_8;
            default:        immediate_length = len_none;
        endcase
    end

    always_comb begin
        opcode_next.valid            = prefix_in.valid;
        opcode_next.operand_size_16  = prefix_in.operand_size_16;
        opcode_next.prefix_count     = prefix_in.prefix_count;
        opcode_next.opcode           = opcode;
        opcode_next.opcode_class     = opcode_class;
        opcode_next.has_modrm        = (opcode_class == op_alu_rm_reg) ||
                                       (opcode_class == op_alu_rm_imm);
        opcode_next.immediate_length = immediate_length;
        opcode_next.window           = {8'h00, prefix_in.window[window_bytes-1:1]};
    end

    always_ff @(posedge clk) begin
        opcode_out <= opcode_next;
        if (rst) begin
            opcode_out.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/decode_stage_3.sv
// decode stage 3, ModR/M and SIB
// splits the ModR/M byte and an optional SIB byte into their fields and
// works out the displacement length under the 32-bit addressing rules
// the window leaves this stage aligned so the displacement starts at byte 0
// instructions without ModR/M pass through with zero fields
module decode_stage_3 (
    input  logic                      clk,
    input  logic                      rst,
    input  decode_pkg::opcode_stage_t opcode_in,
    output decode_pkg::modrm_stage_t  modrm_out
);
    import decode_pkg::*;

    modrm_stage_t modrm_next;
    logic [7:0]   modrm;
    logic [7:0]   sib;
    logic [1:0]   mode;
    logic [2:0]   rm;
    logic         has_sib;
    length_code_t displacement_length;
    logic [1:0]   skip_bytes;     // ModR/M plus SIB bytes in front of the displacement

    assign modrm = opcode_in.window[0];
    assign sib   = opcode_in.window[1];
    assign mode  = modrm[7:6];
    assign rm    = modrm[2:0];

    // rm 100 with a memory operand means a SIB byte follows
    assign has_sib = opcode_in.has_modrm && (rm == 3'b100) && (mode != 2'b11);

    always_comb begin
        displacement_length = len_none;
        if (opcode_in.has_modrm) begin
            unique case (mode)
                2'b01: displacement_length = len_8;
                2'b10: displacement_length = len_32;
                2'b00: begin
                    // disp32 without base, either direct or through SIB base 101
                    if (rm == 3'b101 || (has_sib && sib[2:0] == 3'b101)) begin
                        displacement_length = len_32;
                    end
                end
                default: displacement_length = len_none; // register operand
            endcase
        end
    end

    assign skip_bytes = {1'b0, opcode_in.has_modrm} + {1'b0, has_sib};

    always_comb begin
        modrm_next.valid               = opcode_in.valid;
        modrm_next.operand_size_16     = opcode_in.operand_size_16;
        modrm_next.prefix_count        = opcode_in.prefix_count;
        modrm_next.opcode              = opcode_in.opcode;
        modrm_next.opcode_class        = opcode_in.opcode_class;
        modrm_next.has_modrm           = opcode_in.has_modrm;
        modrm_next.immediate_length    = opcode_in.immediate_length;
        modrm_next.reg_field           = opcode_in.has_modrm ? modrm[5:3] : 3'b000;
        modrm_next.rm                  = opcode_in.has_modrm ? rm : 3'b000;
        modrm_next.has_sib             = has_sib;
        modrm_next.sib_scale           = has_sib ? sib[7:6] : 2'b00;
        modrm_next.sib_index           = has_sib ? sib[5:3] : 3'b000;
        modrm_next.sib_base            = has_sib ? sib[2:0] : 3'b000;
        modrm_next.displacement_length = displacement_length;
        // zero fill from the top as bytes are consumed
        modrm_next.window              = opcode_in.window >> {skip_bytes, 3'b000};
    end

    always_ff @(posedge clk) begin
        modrm_out <= modrm_next;
        if (rst) begin
            modrm_out.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/decode_stage_4.sv
// decode stage 4, displacement and immediate
// takes the displacement little-endian from the aligned window, then the
// immediate from the bytes after it, and adds up the instruction length
// both values come out zero-extended; the consumer sign-extends them from
// the length codes where the instruction asks for it
module decode_stage_4 (
    input  logic                     clk,
    input  logic                     rst,
    input  decode_pkg::modrm_stage_t modrm_in,
    output decode_pkg::decoded_t     decoded
);
    import decode_pkg::*;

    decoded_t        decoded_next;
    logic [31:0]     displacement;
    logic [31:0]     immediate;
    logic [3:0][7:0] immediate_bytes; // window bytes left after the displacement

    always_comb begin
        unique case (modrm_in.displacement_length)
            len_8: begin
                displacement    = {24'h0, modrm_in.window[0]};
                immediate_bytes = modrm_in.window[4:1];
            end
            len_16: begin
                displacement    = {16'h0, modrm_in.window[1:0]};
                immediate_bytes = modrm_in.window[5:2];
            end
            len_32, len_full: begin
                displacement    = modrm_in.window[3:0];
                immediate_bytes = modrm_in.window[7:4];
            end
            default: begin
                displacement    = 32'h0;
                immediate_bytes = modrm_in.window[3:0];
            end
        endcase
    end

    always_comb begin
        unique case (modrm_in.immediate_length)
            len_8:            immediate = {24'h0, immediate_bytes[0]};
            len_16:           immediate = {16'h0, immediate_bytes[1:0]};
            len_32, len_full: immediate = immediate_bytes;
            default:          immediate = 32'h0;
        endcase
    end

    always_comb begin
        decoded_next.valid               = modrm_in.valid;
        decoded_next.opcode_class        = modrm_in.opcode_class;
        decoded_next.opcode              = modrm_in.opcode;
        decoded_next.operand_size_16     = modrm_in.operand_size_16;
        decoded_next.reg_field           = modrm_in.reg_field;
        decoded_next.rm                  = modrm_in.rm;
        decoded_next.has_sib             = modrm_in.has_sib;
        decoded_next.sib_scale           = modrm_in.sib_scale;
        decoded_next.sib_index           = modrm_in.sib_index;
        decoded_next.sib_base            = modrm_in.sib_base;
        decoded_next.displacement        = displacement;
        decoded_next.displacement_length = modrm_in.displacement_length;
        decoded_next.immediate           = immediate;
        decoded_next.immediate_length    = modrm_in.immediate_length;
        // prefix + opcode + modrm + sib + displacement + immediate, at most 12
        decoded_next.instruction_length  = 4'(modrm_in.prefix_count) + 4'd1
                                         + 4'(modrm_in.has_modrm) + 4'(modrm_in.has_sib)
                                         + 4'(length_bytes(modrm_in.displacement_length))
                                         + 4'(length_bytes(modrm_in.immediate_length));
    end

    always_ff @(posedge clk) begin
        decoded <= decoded_next;
        if (rst) begin
            decoded.valid <= 1'b0;
        end
    end

endmodule

// File: hdl/instruction_decoder.sv
// top level of the x86 decoder front
// chains the prefix, opcode, ModR/M and displacement/immediate stages
// a window sampled with window_valid high comes out on decoded four clocks
// later, with decoded.valid high for exactly one cycle per window
// there is no back-pressure, so a new window may enter on every clock
module instruction_decoder (
    input  logic                     clk,
    input  logic                     rst,
    input  decode_pkg::byte_window_t window,
    input  logic                     window_valid,
    output decode_pkg::decoded_t     decoded
);
    import decode_pkg::*;

    prefix_stage_t prefix_stage;  // stage 1 to stage 2
    opcode_stage_t opcode_stage;  // stage 2 to stage 3
    modrm_stage_t  modrm_stage;   // stage 3 to stage 4

    decode_stage_1 i_decode_stage_1 (
        .clk          (clk),
        .rst          (rst),
        .window       (window),
        .window_valid (window_valid),
        .prefix_out   (prefix_stage)
    );

    decode_stage_2 i_decode_stage_2 (
        .clk        (clk),
        .rst        (rst),
        .prefix_in  (prefix_stage),
        .opcode_out (opcode_stage)
    );

    decode_stage_3 i_decode_stage_3 (
        .clk       (clk),
        .rst       (rst),
        .opcode_in (opcode_stage),
        .modrm_out (modrm_stage)
    );

    // last stage registers the output struct itself
    decode_stage_4 i_decode_stage_4 (
        .clk      (clk),
        .rst      (rst),
        .modrm_in (modrm_stage),
        .decoded  (decoded)
    );

endmodule

// File: sim/instruction_decoder_chk.sv
// assertions on the decoder top level, attached with the bind at the bottom
// checks the reset behaviour of decoded.valid, the four-cycle latency of the
// valid strobe and the one-hot form of the length codes
module instruction_decoder_chk (
    input logic                 clk,
    input logic                 rst,
    input logic                 window_valid,
    input decode_pkg::decoded_t decoded
);
    import decode_pkg::*;

    logic [2:0] settle; // clocks since reset was released, saturates at 7

    always_ff @(posedge clk) begin
        if (rst) begin
            settle <= 3'd0;
        end else if (settle != 3'd7) begin
            settle <= settle + 3'd1;
        end
    end

    a_reset_clears_valid: assert property (@(posedge clk) rst && $past(rst) |-> !decoded.valid)
        else $error("decoded.valid high while reset is held");

    // nothing sampled before reset was released may reach the output
    a_quiet_after_reset: assert property (@(posedge clk) disable iff (rst)
        settle < 3'd4 |-> !decoded.valid)
        else $error("decoded.valid high within four cycles of reset");

    a_valid_latency: assert property (@(posedge clk) disable iff (rst)
        settle >= 3'd4 |-> decoded.valid == $past(window_valid, 4))
        else $error("decoded.valid does not follow window_valid four cycles later");

    a_length_onehot: assert property (@(posedge clk) disable iff (rst)
        decoded.valid |-> $onehot0(decoded.displacement_length) &&
                          $onehot0(decoded.immediate_length))
        else $error("length code is neither one-hot nor zero");

endmodule

bind instruction_decoder instruction_decoder_chk i_instruction_decoder_chk (
    .clk          (clk),
    .rst          (rst),
    .window_valid (window_valid),
    .decoded      (decoded)
);

// File: sim/instruction_decoder_tb.sv
// testbench for the four-stage x86 decoder front
// drives byte windows a few time units after each rising edge, predicts every
// decoded field with decode_ref and compares the outputs in order on the
// falling edge, one summary line per test and a closing count line
module instruction_decoder_tb;
    import decode_pkg::*;

    localparam int clock_period   = 40;
    localparam int drive_delay    = 5;
    localparam int reset_cycles   = 8;
    localparam int pipeline_depth = 4;
    localparam int total_windows  = 3 + 64 + 52 + 256 + 300;
    localparam int cycle_limit    = total_windows + pipeline_depth + 100;

    logic         clk = 1'b0;
    logic         rst;
    byte_window_t window;
    logic         window_valid;
    decoded_t     decoded;

    decoded_t expected_queue[$];
    int       drive_cycle_queue[$]; // cycle in which each window was driven
    int       cycle_count = 0;
    int       error_count = 0;
    int       windows_sent = 0;
    int       test_first_error;
    int       test_first_sent;

    instruction_decoder i_instruction_decoder (
        .clk          (clk),
        .rst          (rst),
        .window       (window),
        .window_valid (window_valid),
        .decoded      (decoded)
    );

    always #(clock_period / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
    end

    function automatic logic [7:0] byte_at(input byte_window_t w, input logic [3:0] index);
        if (int'(index) < window_bytes) begin
            return w[index];
        end
        return 8'h00;
    endfunction

    function automatic length_code_t code_for_bytes(input int count);
        case (count)
            1:       return 4'b0001;
            2:       return 4'b0010;
            4:       return 4'b0100;
            default: return 4'b0000;
        endcase
    endfunction

    // walks the window byte by byte with pos pointing at the next unread byte
    function automatic decoded_t decode_ref(input byte_window_t w);
        decoded_t   d;
        logic [3:0] pos;
        logic [7:0] op;
        logic [7:0] modrm;
        logic [7:0] sib;
        int         full_bytes;
        int         disp_bytes;
        int         imm_bytes;
        d = '0;
        d.valid = 1'b1;
        pos = 4'd0;
        if (w[0] == 8'h66) begin
            d.operand_size_16 = 1'b1;
            pos = 4'd1;
        end
        op = byte_at(w, pos);
        pos = pos + 4'd1;
        d.opcode = op;
        if (op < 8'h40 && op[2:0] < 3'd4) begin
            d.opcode_class = op_alu_rm_reg;
        end else if (op < 8'h40 && (op[2:0] == 3'd4 || op[2:0] == 3'd5)) begin
            d.opcode_class = op_alu_acc_imm;
        end else if (op == 8'h80 || op == 8'h81 || op == 8'h83) begin
            d.opcode_class = op_alu_rm_imm;
        end else if (op[7:4] == 4'hb) begin
            d.opcode_class = op_mov_reg_imm;
        end else begin
            d.opcode_class = op_invalid;
        end
        full_bytes = d.operand_size_16 ? 2 : 4;
        imm_bytes = 0;
        if (d.opcode_class == op_mov_reg_imm) begin
            imm_bytes = (op < 8'hb8) ? 1 : full_bytes;
        end else if (d.opcode_class == op_alu_acc_imm || d.opcode_class == op_alu_rm_imm) begin
            imm_bytes = (op == 8'h83 || op[0] == 1'b0) ? 1 : full_bytes;
        end
        disp_bytes = 0;
        if (d.opcode_class == op_alu_rm_reg || d.opcode_class == op_alu_rm_imm) begin
            modrm = byte_at(w, pos);
            pos = pos + 4'd1;
            d.reg_field = modrm[5:3];
            d.rm = modrm[2:0];
            if (modrm[7:6] != 2'b11 && modrm[2:0] == 3'b100) begin
                sib = byte_at(w, pos);
                pos = pos + 4'd1;
                d.has_sib = 1'b1;
                d.sib_scale = sib[7:6];
                d.sib_index = sib[5:3];
                d.sib_base = sib[2:0];
            end
            if (modrm[7:6] == 2'b01) begin
                disp_bytes = 1;
            end else if (modrm[7:6] == 2'b10) begin
                disp_bytes = 4;
            end else if (modrm[7:6] == 2'b00 && (modrm[2:0] == 3'b101 ||
                         (d.has_sib && d.sib_base == 3'b101))) begin
                disp_bytes = 4; // absolute disp32 without a base register
            end
        end
        for (int i = 0; i < disp_bytes; i++) begin
            d.displacement = d.displacement | (32'(byte_at(w, pos)) << (8 * i));
            pos = pos + 4'd1;
        end
        for (int i = 0; i < imm_bytes; i++) begin
            d.immediate = d.immediate | (32'(byte_at(w, pos)) << (8 * i));
            pos = pos + 4'd1;
        end
        d.displacement_length = code_for_bytes(disp_bytes);
        d.immediate_length = code_for_bytes(imm_bytes);
        d.instruction_length = pos;
        return d;
    endfunction

    function automatic byte_window_t random_window();
        return {$urandom(), $urandom(), $urandom()};
    endfunction

    function automatic byte_window_t with_prefix(input byte_window_t w);
        return {w[window_bytes-2:0], 8'h66};
    endfunction

    // 0 to 9 are the ALU immediate forms, 10 to 25 the moves b0 to bf
    function automatic logic [7:0] immediate_opcode(input int k);
        case (k)
            0:       return 8'h80;
            1:       return 8'h81;
            2:       return 8'h83;
            3:       return 8'h04;
            4:       return 8'h05;
            5:       return 8'h0c;
            6:       return 8'h25;
            7:       return 8'h2c;
            8:       return 8'h3c;
            9:       return 8'h3d;
            default: return 8'hb0 + 8'(k - 10);
        endcase
    endfunction

    function automatic byte_window_t supported_window();
        byte_window_t w;
        logic [1:0]   pick;
        w = random_window();
        pick = 2'($urandom);
        case (pick)
            2'd0:    w[0] = {2'b00, 3'($urandom), 1'b0, 2'($urandom)};
            2'd1:    w[0] = {2'b00, 3'($urandom), 2'b10, 1'($urandom)};
            2'd2:    w[0] = immediate_opcode(int'($urandom % 3));
            default: w[0] = {4'hb, 4'($urandom)};
        endcase
        if ($urandom % 2 == 1) begin
            w = with_prefix(w);
        end
        return w;
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            error_count++;
            $display("error: %s got 0x%0h expected 0x%0h", name, got, expected);
        end
    endtask

    task automatic compare_result(input decoded_t expected, input int drive_cycle);
        check_value("latency", 32'(cycle_count - drive_cycle), 32'(pipeline_depth));
        check_value("opcode_class", 32'(decoded.opcode_class), 32'(expected.opcode_class));
        check_value("opcode", 32'(decoded.opcode), 32'(expected.opcode));
        check_value("operand_size_16", 32'(decoded.operand_size_16),
                    32'(expected.operand_size_16));
        check_value("reg_field", 32'(decoded.reg_field), 32'(expected.reg_field));
        check_value("rm", 32'(decoded.rm), 32'(expected.rm));
        check_value("has_sib", 32'(decoded.has_sib), 32'(expected.has_sib));
        check_value("sib_scale", 32'(decoded.sib_scale), 32'(expected.sib_scale));
        check_value("sib_index", 32'(decoded.sib_index), 32'(expected.sib_index));
        check_value("sib_base", 32'(decoded.sib_base), 32'(expected.sib_base));
        check_value("displacement", decoded.displacement, expected.displacement);
        check_value("displacement_length", 32'(decoded.displacement_length),
                    32'(expected.displacement_length));
        check_value("immediate", decoded.immediate, expected.immediate);
        check_value("immediate_length", 32'(decoded.immediate_length),
                    32'(expected.immediate_length));
        check_value("instruction_length", 32'(decoded.instruction_length),
                    32'(expected.instruction_length));
    endtask

    task automatic send_window(input byte_window_t w);
        @(posedge clk);
        #drive_delay;
        window = w;
        window_valid = 1'b1;
        expected_queue.push_back(decode_ref(w));
        drive_cycle_queue.push_back(cycle_count);
        windows_sent++;
    endtask

    task automatic drive_idle();
        @(posedge clk);
        #drive_delay;
        window = random_window(); // data is ignored while valid is low
        window_valid = 1'b0;
    endtask

    task automatic wait_empty();
        while (expected_queue.size() != 0) begin
            @(negedge clk);
        end
    endtask

    task automatic start_test();
        test_first_error = error_count;
        test_first_sent = windows_sent;
    endtask

    task automatic finish_test(input string name);
        drive_idle();
        wait_empty();
        $display("test %s: %0d windows, %0d errors", name, windows_sent - test_first_sent,
                 error_count - test_first_error);
    endtask

    // every output must belong to a window that is still outstanding
    always @(negedge clk) begin
        if (decoded.valid === 1'b1) begin
            if (expected_queue.size() == 0) begin
                error_count++;
                $display("decoder produced an output at cycle %0d with no window outstanding",
                         cycle_count);
            end else begin
                compare_result(expected_queue.pop_front(), drive_cycle_queue.pop_front());
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
        end
        $display("timeout after %0d cycles with %0d windows still in the pipeline",
                 cycle_count, expected_queue.size());
        $display("*** FAILED ***");
        $finish;
    end

    initial begin : stimulus
        byte_window_t w;
        void'($urandom(75));
        rst = 1'b1;
        window = '0;
        window_valid = 1'b1; // windows offered during reset must never come out
        repeat (reset_cycles) @(posedge clk);
        #drive_delay;
        rst = 1'b0;
        window_valid = 1'b0;

        start_test();
        repeat (6) drive_idle();
        repeat (3) begin
            send_window(supported_window());
            drive_idle();
            wait_empty();
        end
        finish_test("reset_and_latency");

        start_test();
        for (int mode = 0; mode < 4; mode++) begin
            for (int rm_sel = 0; rm_sel < 8; rm_sel++) begin
                for (int base_sel = 0; base_sel < 2; base_sel++) begin
                    w = random_window();
                    w[0] = {2'b00, 3'(rm_sel), 1'b0, 2'(mode)};
                    w[1] = {2'(mode), 3'($urandom), 3'(rm_sel)};
                    w[2] = {2'($urandom), 3'($urandom), (base_sel == 1) ? 3'b101 : 3'b000};
                    send_window(w);
                end
            end
        end
        finish_test("alu_register_forms");

        start_test();
        for (int k = 0; k < 26; k++) begin
            for (int p = 0; p < 2; p++) begin
                w = random_window();
                w[0] = immediate_opcode(k);
                if (p == 1) begin
                    w = with_prefix(w);
                end
                send_window(w);
            end
        end
        finish_test("immediate_forms");

        start_test();
        for (int op = 0; op < 256; op++) begin
            w = random_window();
            w[0] = 8'(op);
            send_window(w);
        end
        finish_test("every_opcode_length");

        start_test();
        repeat (300) send_window(supported_window());
        finish_test("random_stream");

        $display("windows %0d, errors %0d", windows_sent, error_count);
        if (error_count == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// File: project.f
hdl/decode_pkg.sv
hdl/decode_stage_1.sv
hdl/decode_stage_2.sv
hdl/decode_stage_3.sv
hdl/decode_stage_4.sv
hdl/instruction_decoder.sv
sim/instruction_decoder_chk.sv
sim/instruction_decoder_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# builds the decoder testbench with Verilator, runs it into sim.log and
# scans the log for the failure line
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -f project.f \
    --top-module instruction_decoder_tb -Mdir obj_dir

./obj_dir/Vinstruction_decoder_tb | tee sim.log

if grep -qF '*** FAILED ***' sim.log; then
    echo "simulation reported a failure, see sim.log"
    exit 1
fi
echo "simulation finished without failures"
